/* logic/lidar_pkg.sv */
package lidar_pkg;

  // Channel count
  localparam int NUM_CHANNELS = 6;

  // Channel number as carried in records
  typedef logic [2:0] chan_idx_t;
  // Running shot number, wraps
  typedef logic [7:0] shot_cnt_t;
  // One TDC measurement
  typedef logic [15:0] tdc_result_t;
  // One SPI frame, command on top, result in the low half
  typedef logic [23:0] spi_word_t;

  // TDC read opcode
  localparam logic [7:0] TDC_READ_RESULT_CMD = 8'h90;
  // Reported when no echo arrives in time
  localparam tdc_result_t NO_ECHO_RESULT = 16'hFFFF;

  // Shooting rate, clocks between fires
  localparam int SHOT_PERIOD_CYCLES = 800;
  // Start pulse width to the TDC
  localparam int START_PULSE_CYCLES = 2;
  // Echo wait after the start pulse ends
  localparam int ECHO_TIMEOUT_CYCLES = 64;

  // SPI clock half period
  localparam int SPI_HALF_PERIOD_CYCLES = 2;

  // Serial line bit length
  localparam int UART_CLKS_PER_BIT = 4;
  // Channel, shot, result high, result low
  localparam int RECORD_BYTES = 4;

  // Channel sequence
  typedef enum logic [2:0] {IDLE, FIRE, WAIT_ECHO, READ, OFFER} chan_state_t;

  // Collector sequence
  typedef enum logic [1:0] {SCAN, LATCH, SEND} coll_state_t;

endpackage

/* logic/tdc_result_if.sv */
`timescale 1ns/100ps

interface tdc_result_if;
  import lidar_pkg::*;

  // Four-phase handshake
  logic req;
  logic ack;
  // Payload, stable while req is high
  tdc_result_t result;
  shot_cnt_t shot;

  // Channel side
  modport source (output req, output result, output shot, input ack);

  // Collector side
  modport sink (input req, input result, input shot, output ack);

endinterface

/* logic/shot_sequencer.sv */
`timescale 1ns/100ps

module shot_sequencer (
  input  logic                 clk,
  input  logic                 arst_n,
  output logic                 fire,
  output lidar_pkg::shot_cnt_t shot
);
  import lidar_pkg::*;

  // Clocks since the last fire
  logic [$clog2(SHOT_PERIOD_CYCLES)-1:0] period_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      fire       <= 1'b0;
      // All ones so the first fire carries shot 0
      shot       <= '1;
    end else begin
      fire <= 1'b0;
      if (period_cnt == SHOT_PERIOD_CYCLES - 1) begin
        period_cnt <= '0;
        // One-cycle strobe to all channels
        fire       <= 1'b1;
        shot       <= shot + 1'b1;
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/tdc_spi_master.sv */
`timescale 1ns/100ps

module tdc_spi_master (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  lidar_pkg::spi_word_t tx_word,
  output lidar_pkg::spi_word_t rx_word,
  output logic                 busy,
  output logic                 done,
  output logic                 sck,
  output logic                 mosi,
  output logic                 cs_n,
  input  logic                 miso
);
  import lidar_pkg::*;

  // Clocks within one SCK half period
  logic [$clog2(SPI_HALF_PERIOD_CYCLES + 1)-1:0] div_cnt;
  // SCK periods already completed
  logic [$clog2($bits(spi_word_t))-1:0] bit_cnt;
  spi_word_t tx_shift;
  logic half_tick;
  logic sck_rise;
  logic sck_fall;
  logic last_bit;

  assign half_tick = busy && (div_cnt == SPI_HALF_PERIOD_CYCLES - 1);
  assign sck_rise  = half_tick && !sck;
  assign sck_fall  = half_tick && sck;
  assign last_bit  = (bit_cnt == $bits(spi_word_t) - 1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      sck     <= 1'b0;
      mosi    <= 1'b0;
      cs_n    <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy    <= 1'b1;
          cs_n    <= 1'b0;
          // MSB set up ahead of the first rising edge
          mosi    <= tx_word[$bits(spi_word_t)-1];
          div_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (half_tick) begin
        div_cnt <= '0;
        sck     <= ~sck;
        if (sck_fall && last_bit) begin
          // Frame ends on the last falling edge
          busy <= 1'b0;
          done <= 1'b1;
          cs_n <= 1'b1;
          mosi <= 1'b0;
        end else if (sck_fall) begin
          bit_cnt <= bit_cnt + 1'b1;
          mosi    <= tx_shift[$bits(spi_word_t)-2];
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Shift registers
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      tx_shift <= tx_word;
    end else if (sck_fall && !last_bit) begin
      tx_shift <= {tx_shift[$bits(spi_word_t)-2:0], 1'b0};
    end
    // Mode 0, sample on rising edge
    if (sck_rise) begin
      rx_word <= {rx_word[$bits(spi_word_t)-2:0], miso};
    end
  end

  // Chip select never left low outside a frame
  assert property (@(posedge clk) disable iff (!arst_n) !busy |-> cs_n)
    else $error("SPI chip select low while idle");

endmodule

/* logic/tdc_channel.sv */
`timescale 1ns/100ps

module tdc_channel (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 fire,
  input  lidar_pkg::shot_cnt_t shot,
  input  logic                 tdc_intb,
  input  logic                 tdc_dout,
  output logic                 tdc_start,
  output logic                 tdc_sck,
  output logic                 tdc_mosi,
  output logic                 tdc_cs_n,
  tdc_result_if.source         res
);
  import lidar_pkg::*;

  chan_state_t state;
  // Start pulse and echo timeout counter
  logic [$clog2(ECHO_TIMEOUT_CYCLES + START_PULSE_CYCLES)-1:0] cnt;
  // Interrupt synchronizer, bit 1 is safe to use
  logic [1:0] intb_sync;
  logic echo_seen;
  logic echo_timeout;
  logic spi_start;
  logic spi_busy;
  logic spi_done;
  spi_word_t spi_tx;
  spi_word_t spi_rx;

  // Read command, data half don't care
  assign spi_tx = {TDC_READ_RESULT_CMD, {$bits(tdc_result_t){1'b0}}};

  assign echo_seen    = !intb_sync[1];
  assign echo_timeout = (state == WAIT_ECHO) && !echo_seen &&
                        (cnt == ECHO_TIMEOUT_CYCLES - 1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      intb_sync <= 2'b11;
    end else begin
      intb_sync <= {intb_sync[0], tdc_intb};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      cnt       <= '0;
      tdc_start <= 1'b0;
      spi_start <= 1'b0;
      res.req   <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      case (state)
        // Fire is dropped outside IDLE
        IDLE: begin
          if (fire) begin
            tdc_start <= 1'b1;
            cnt       <= '0;
            state     <= FIRE;
          end
        end
        FIRE: begin
          if (cnt == START_PULSE_CYCLES - 1) begin
            tdc_start <= 1'b0;
            cnt       <= '0;
            state     <= WAIT_ECHO;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        WAIT_ECHO: begin
          if (echo_seen) begin
            spi_start <= 1'b1;
            state     <= READ;
          end else if (echo_timeout) begin
            // No frame on a missing echo
            res.req <= 1'b1;
            state   <= OFFER;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        READ: begin
          if (spi_done) begin
            res.req <= 1'b1;
            state   <= OFFER;
          end
        end
        OFFER: begin
          // Drop req on ack, leave once ack is gone too
          if (res.ack) begin
            res.req <= 1'b0;
          end else if (!res.req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Offered payload
  always_ff @(posedge clk) begin
    if (state == IDLE && fire) begin
      res.shot <= shot;
    end
    if (echo_timeout) begin
      res.result <= NO_ECHO_RESULT;
    end else if (state == READ && spi_done) begin
      res.result <= spi_rx[$bits(tdc_result_t)-1:0];
    end
  end

  tdc_spi_master u_spi (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (spi_start),
    .tx_word (spi_tx),
    .rx_word (spi_rx),
    .busy    (spi_busy),
    .done    (spi_done),
    .sck     (tdc_sck),
    .mosi    (tdc_mosi),
    .cs_n    (tdc_cs_n),
    .miso    (tdc_dout)
  );

  // Payload frozen during an open request
  assert property (@(posedge clk) disable iff (!arst_n)
    res.req && !res.ack |=> $stable(res.result) && $stable(res.shot))
    else $error("Result changed while offered");

  // SPI traffic only during readout
  assert property (@(posedge clk) disable iff (!arst_n) spi_busy |-> state == READ)
    else $error("SPI busy outside readout");

endmodule

/* logic/result_collector.sv */
`timescale 1ns/100ps

module result_collector (
  input  logic       clk,
  input  logic       arst_n,
  tdc_result_if.sink res [lidar_pkg::NUM_CHANNELS],
  output logic       serial_tx
);
  import lidar_pkg::*;

  coll_state_t state;
  logic [NUM_CHANNELS-1:0] req_vec;
  logic [NUM_CHANNELS-1:0] ack_vec;
  logic [NUM_CHANNELS-1:0] pending;
  tdc_result_t result_arr [NUM_CHANNELS];
  shot_cnt_t shot_arr [NUM_CHANNELS];
  // Current, and afterwards last, granted channel
  chan_idx_t grant;
  chan_idx_t winner;
  logic found;
  // Four 8N1 frames, first frame in the low bits
  logic [RECORD_BYTES*10-1:0] record;
  logic [RECORD_BYTES*10-1:0] frame_sr;
  logic [$clog2(UART_CLKS_PER_BIT + 1)-1:0] clk_cnt;
  logic [$clog2(RECORD_BYTES*10)-1:0] bit_cnt;
  logic bit_tick;

  // Start bit low, LSB first, stop bit high
  function automatic logic [9:0] uart_frame(input logic [7:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_map
    assign req_vec[i]    = res[i].req;
    assign result_arr[i] = res[i].result;
    assign shot_arr[i]   = res[i].shot;
    assign res[i].ack    = ack_vec[i];

    // Handshake order per channel
    assert property (@(posedge clk) disable iff (!arst_n) $rose(ack_vec[i]) |-> req_vec[i])
      else $error("ack raised without req");
  end

  // Open requests not yet acknowledged
  assign pending = req_vec & ~ack_vec;

  // Round robin, search starts after the last grant
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = grant;
    for (int off = 1; off <= NUM_CHANNELS; off++) begin
      idx = (int'(grant) + off) % NUM_CHANNELS;
      if (!found && pending[idx]) begin
        found  = 1'b1;
        winner = chan_idx_t'(idx);
      end
    end
  end

  always_comb begin
    record = {uart_frame(result_arr[grant][7:0]),
              uart_frame(result_arr[grant][15:8]),
              uart_frame(shot_arr[grant]),
              uart_frame(8'(grant))};
  end

  assign bit_tick = (state == SEND) && (clk_cnt == UART_CLKS_PER_BIT - 1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= SCAN;
      grant     <= chan_idx_t'(NUM_CHANNELS - 1);
      ack_vec   <= '0;
      serial_tx <= 1'b1;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
    end else begin
      // Release ack once its req is gone
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        if (ack_vec[i] && !req_vec[i]) begin
          ack_vec[i] <= 1'b0;
        end
      end
      case (state)
        SCAN: begin
          if (found) begin
            grant <= winner;
            state <= LATCH;
          end
        end
        LATCH: begin
          // Payload captured this cycle
          ack_vec[grant] <= 1'b1;
          serial_tx      <= record[0];
          clk_cnt        <= '0;
          bit_cnt        <= '0;
          state          <= SEND;
        end
        SEND: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            if (bit_cnt == RECORD_BYTES*10 - 1) begin
              serial_tx <= 1'b1;
              state     <= SCAN;
            end else begin
              bit_cnt   <= bit_cnt + 1'b1;
              serial_tx <= frame_sr[0];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= SCAN;
      endcase
    end
  end

  // Record shifter, bit 0 already on the line
  always_ff @(posedge clk) begin
    if (state == LATCH) begin
      frame_sr <= record >> 1;
    end else if (bit_tick) begin
      frame_sr <= frame_sr >> 1;
    end
  end

endmodule

/* logic/lidar_top.sv */
`timescale 1ns/100ps

module lidar_top (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_intb,
  input  logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_dout,
  output logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_start,
  output logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_cs_n,
  output logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_sck,
  output logic [lidar_pkg::NUM_CHANNELS-1:0] tdc_mosi,
  output logic                              serial_tx
);
  import lidar_pkg::*;

  // Shared shooting strobe
  logic fire;
  shot_cnt_t shot;

  // One handshake per channel
  tdc_result_if res_if [NUM_CHANNELS] ();

  shot_sequencer u_seq (
    .clk    (clk),
    .arst_n (arst_n),
    .fire   (fire),
    .shot   (shot)
  );

  // All channels fire together, each on its own SPI pins
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    tdc_channel u_chan (
      .clk       (clk),
      .arst_n    (arst_n),
      .fire      (fire),
      .shot      (shot),
      .tdc_intb  (tdc_intb[i]),
      .tdc_dout  (tdc_dout[i]),
      .tdc_start (tdc_start[i]),
      .tdc_sck   (tdc_sck[i]),
      .tdc_mosi  (tdc_mosi[i]),
      .tdc_cs_n  (tdc_cs_n[i]),
      .res       (res_if[i])
    );
  end

  result_collector u_coll (
    .clk       (clk),
    .arst_n    (arst_n),
    .res       (res_if),
    .serial_tx (serial_tx)
  );

endmodule

/* test/tdc_slave_model.sv */
`timescale 1ns/100ps

module tdc_slave_model #(
  parameter int CHANNEL = 0,
  parameter int SEED    = 0
) (
  input  logic clk,
  input  logic arst_n,
  input  logic tdc_start,
  input  logic tdc_sck,
  input  logic tdc_mosi,
  input  logic tdc_cs_n,
  output logic tdc_intb,
  output logic tdc_dout,
  output logic fault
);
  import lidar_pkg::*;

  int seed;
  int cyc;
  int shot_num;
  int echo_cnt;
  int tx_idx;
  int rx_bits;
  logic prev_start;
  logic prev_sck;
  logic prev_cs;
  logic silent;
  logic [7:0] cmd;
  spi_word_t tx_word;

  initial begin
    seed     = SEED + CHANNEL * 7919;
    tdc_intb = 1'b1;
    tdc_dout = 1'b0;
    fault    = 1'b0;
  end

  // Pins seen here are the values from before this edge
  always @(posedge clk) begin
    if (!arst_n) begin
      cyc        = 0;
      echo_cnt   = -1;
      silent     = 1'b0;
      prev_start = 1'b0;
      prev_sck   = 1'b0;
      prev_cs    = 1'b1;
      tdc_intb  <= 1'b1;
      tdc_dout  <= 1'b0;
    end else begin
      // Shot number from the firing grid
      if (tdc_start && !prev_start) begin
        shot_num = (cyc - 1) / SHOT_PERIOD_CYCLES - 1;
        silent   = (CHANNEL == 5) && (shot_num % 4 == 0);
      end
      // Random echo delay of 3 to 40 cycles after the start pulse
      if (!tdc_start && prev_start) begin
        echo_cnt = 3 + ($unsigned($random(seed)) % 38);
      end else if (echo_cnt > 0) begin
        echo_cnt = echo_cnt - 1;
        if (echo_cnt == 0) begin
          if (!silent) begin
            tdc_intb <= 1'b0;
          end
          echo_cnt = -1;
        end
      end
      // Frame begins, answer word loaded
      if (prev_cs && !tdc_cs_n) begin
        tdc_intb <= 1'b1;
        if (silent) begin
          $display("Channel %0d: SPI frame during a shot without echo", CHANNEL);
          fault <= 1'b1;
        end
        tx_word  = {8'h00, 4'(CHANNEL), 4'h0, 8'(shot_num)};
        tdc_dout <= tx_word[23];
        tx_idx   = 22;
        rx_bits  = 0;
        cmd      = '0;
      end
      if ((tdc_sck != prev_sck) && tdc_cs_n && prev_cs) begin
        $display("Channel %0d: SCK toggled while chip select was high", CHANNEL);
        fault <= 1'b1;
      end
      // Rising SCK, collect the command byte
      if (tdc_sck && !prev_sck && !tdc_cs_n && rx_bits < 8) begin
        cmd     = {cmd[6:0], tdc_mosi};
        rx_bits = rx_bits + 1;
        if (rx_bits == 8 && cmd != TDC_READ_RESULT_CMD) begin
          $display("Channel %0d: wrong command byte %h", CHANNEL, cmd);
          fault <= 1'b1;
        end
      end
      // Falling SCK, next answer bit
      if (!tdc_sck && prev_sck && !tdc_cs_n && tx_idx >= 0) begin
        tdc_dout <= tx_word[tx_idx];
        tx_idx = tx_idx - 1;
      end
      cyc        = cyc + 1;
      prev_start = tdc_start;
      prev_sck   = tdc_sck;
      prev_cs    = tdc_cs_n;
    end
  end

endmodule

/* test/lidar_tb.sv */
`timescale 1ns/100ps

module lidar_tb;
  import lidar_pkg::*;

  localparam int RANDOM_SEED = 32'h8f1d;
  localparam int LAST_SHOT = 15;

  logic clk;
  logic arst_n;
  logic [NUM_CHANNELS-1:0] tdc_intb;
  logic [NUM_CHANNELS-1:0] tdc_dout;
  logic [NUM_CHANNELS-1:0] tdc_start;
  logic [NUM_CHANNELS-1:0] tdc_cs_n;
  logic [NUM_CHANNELS-1:0] tdc_sck;
  logic [NUM_CHANNELS-1:0] tdc_mosi;
  logic [NUM_CHANNELS-1:0] model_fault;
  logic serial_tx;

  int cyc;
  logic [NUM_CHANNELS-1:0] prev_start;
  logic [NUM_CHANNELS-1:0] prev_cs;
  int high_len [NUM_CHANNELS];
  int fired_shot [NUM_CHANNELS];
  // Last fired shot per channel, frozen at the record's start bit
  int start_shot [NUM_CHANNELS];
  // Readouts finished, and records seen, per channel
  int ready_cnt [NUM_CHANNELS];
  int ready_at [NUM_CHANNELS];
  int served_cnt [NUM_CHANNELS];
  int last_shot [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] finished;
  logic [RECORD_BYTES*10-1:0] line_bits;

  always #5 clk = ~clk;

  lidar_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .tdc_intb  (tdc_intb),
    .tdc_dout  (tdc_dout),
    .tdc_start (tdc_start),
    .tdc_cs_n  (tdc_cs_n),
    .tdc_sck   (tdc_sck),
    .tdc_mosi  (tdc_mosi),
    .serial_tx (serial_tx)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_model
    tdc_slave_model #(.CHANNEL(i), .SEED(RANDOM_SEED)) u_model (
      .clk       (clk),
      .arst_n    (arst_n),
      .tdc_start (tdc_start[i]),
      .tdc_sck   (tdc_sck[i]),
      .tdc_mosi  (tdc_mosi[i]),
      .tdc_cs_n  (tdc_cs_n[i]),
      .tdc_intb  (tdc_intb[i]),
      .tdc_dout  (tdc_dout[i]),
      .fault     (model_fault[i])
    );
  end

  // Channel in the top nibble, shot below, silent channel 5 on every fourth shot
  function automatic tdc_result_t expected_result(input int chan, input int shot);
    if (chan == 5 && shot % 4 == 0) begin
      return NO_ECHO_RESULT;
    end
    return {4'(chan), 12'(shot)};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // Pin monitor, start pulses and readout completion
  always @(posedge clk) begin
    if (!arst_n) begin
      cyc        <= 0;
      prev_start <= '0;
      prev_cs    <= '1;
    end else begin
      if (|model_fault) begin
        abort_run("TDC model detected an SPI protocol violation");
      end
      if (cyc < SHOT_PERIOD_CYCLES) begin
        check_equal("idle_serial_tx", 1, serial_tx);
        check_equal("idle_cs_n", {NUM_CHANNELS{1'b1}}, tdc_cs_n);
        check_equal("idle_start", 0, tdc_start);
      end
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        if (tdc_start[ch] && !prev_start[ch]) begin
          // Every start on the common firing grid
          check_equal("start_timing", 0,
                      (cyc > SHOT_PERIOD_CYCLES) ? (cyc - 1) % SHOT_PERIOD_CYCLES : 1);
          fired_shot[ch] = (cyc - 1) / SHOT_PERIOD_CYCLES - 1;
          high_len[ch]   = 1;
        end else if (tdc_start[ch]) begin
          high_len[ch]++;
        end
        if (!tdc_start[ch] && prev_start[ch]) begin
          check_equal("start_width", START_PULSE_CYCLES, high_len[ch]);
          if (ch == 5 && fired_shot[ch] % 4 == 0) begin
            ready_at[ch] = cyc + ECHO_TIMEOUT_CYCLES;
            ready_cnt[ch]++;
          end
        end
        if (tdc_cs_n[ch] && !prev_cs[ch]) begin
          ready_at[ch] = cyc;
          ready_cnt[ch]++;
        end
      end
      cyc        <= cyc + 1;
      prev_start <= tdc_start;
      prev_cs    <= tdc_cs_n;
    end
  end

  // Serial decoder, one record of four 8N1 frames
  task automatic read_record(output int start_cyc);
    int wait_cnt;
    wait_cnt = 0;
    while (serial_tx !== 1'b0) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > 2 * SHOT_PERIOD_CYCLES) begin
        abort_run("No serial record arrived in time");
      end
    end
    start_cyc = cyc;
    // Granted channel may fire again while its record is on the line
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      start_shot[ch] = fired_shot[ch];
    end
    // Move to mid-bit
    @(posedge clk);
    line_bits[0] = serial_tx;
    for (int b = 1; b < RECORD_BYTES * 10; b++) begin
      repeat (UART_CLKS_PER_BIT) @(posedge clk);
      line_bits[b] = serial_tx;
    end
    for (int f = 0; f < RECORD_BYTES; f++) begin
      check_equal("start_bit", 0, line_bits[f*10]);
      check_equal("stop_bit", 1, line_bits[f*10+9]);
    end
  endtask

  task automatic check_record(input int start_cyc, inout int last_chan);
    int chan;
    int shot;
    int j;
    tdc_result_t result;
    chan   = line_bits[8:1];
    shot   = line_bits[18:11];
    result = {line_bits[28:21], line_bits[38:31]};
    check_equal("channel_range", 1, chan < NUM_CHANNELS);
    check_equal("record_pending", 1, ready_cnt[chan] > served_cnt[chan]);
    check_equal("record_shot", start_shot[chan], shot);
    check_equal("result", expected_result(chan, shot), result);
    check_equal("shot_order", 1, shot > last_shot[chan]);
    // A skipped channel must not have been waiting
    if (last_chan >= 0) begin
      j = (last_chan + 1) % NUM_CHANNELS;
      while (j != chan) begin
        if (ready_cnt[j] > served_cnt[j] && ready_at[j] + 8 <= start_cyc) begin
          check_equal("round_robin", j, chan);
        end
        j = (j + 1) % NUM_CHANNELS;
      end
    end
    served_cnt[chan]++;
    last_shot[chan] = shot;
    last_chan       = chan;
    if (shot >= LAST_SHOT) begin
      finished[chan] = 1'b1;
    end
  endtask

  initial begin
    int start_cyc;
    int last_chan;
    clk         = 1'b0;
    arst_n      = 1'b0;
    last_chan   = -1;
    finished    = '0;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      ready_cnt[ch]  = 0;
      served_cnt[ch] = 0;
      ready_at[ch]   = 0;
      last_shot[ch]  = -1;
      fired_shot[ch] = -1;
      start_shot[ch] = -1;
      high_len[ch]   = 0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    while (!(&finished)) begin
      read_record(start_cyc);
      check_record(start_cyc, last_chan);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* files.f */
logic/lidar_pkg.sv
logic/tdc_result_if.sv
logic/shot_sequencer.sv
logic/tdc_spi_master.sv
logic/tdc_channel.sv
logic/result_collector.sv
logic/lidar_top.sv
test/tdc_slave_model.sv
test/lidar_tb.sv

/* Bender.yml */
package:
  name: lidar_readout

sources:
  - logic/lidar_pkg.sv
  - logic/tdc_result_if.sv
  - logic/shot_sequencer.sv
  - logic/tdc_spi_master.sv
  - logic/tdc_channel.sv
  - logic/result_collector.sv
  - logic/lidar_top.sv
  - target: simulation
    files:
      - test/tdc_slave_model.sv
      - test/lidar_tb.sv
